/* src/radio_cfg_pkg.sv */
package radio_cfg_pkg;

   ////////////////////////////////
   // Settings bus
   ////////////////////////////////
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   localparam logic [SET_ADDR_W-1:0] SR_TEST      = 8'd7;
   localparam logic [SET_ADDR_W-1:0] SR_MISC_OUTS = 8'd24;
   localparam logic [SET_ADDR_W-1:0] SR_RUN       = 8'd28;   // Bit 0 run_rx, bit 1 run_tx
   localparam logic [SET_ADDR_W-1:0] SR_TIME      = 8'd128;  // +0 high word, +1 low word and load

   ////////////////////////////////
   // GPIO banks
   ////////////////////////////////
   localparam int NUM_GPIO_BANKS = 3;
   localparam int GPIO_W         = 32;

   // Daughterboard, second daughterboard, front panel
   localparam logic [SET_ADDR_W-1:0] GPIO_BASES [NUM_GPIO_BANKS] = '{8'd16, 8'd116, 8'd200};

   // Offsets 0 to 3 follow the ATR state order
   localparam logic [SET_ADDR_W-1:0] GPIO_OFF_DDR = 8'd4;

   typedef enum logic [1:0] {
      ATR_IDLE = 2'd0,
      ATR_RX   = 2'd1,
      ATR_TX   = 2'd2,
      ATR_FDX  = 2'd3
   } atr_state_t;

   ////////////////////////////////
   // Status and readback
   ////////////////////////////////
   localparam int MISC_W   = 8;
   localparam int TIME_W   = 64;
   localparam int RB_W     = 64;
   localparam int RB_SEL_W = 3;
   localparam int RB_SLOTS = 5;

   localparam logic [RB_SEL_W-1:0] RB_SLOT_TEST    = 3'd0;
   localparam logic [RB_SEL_W-1:0] RB_SLOT_TIME    = 3'd1;
   localparam logic [RB_SEL_W-1:0] RB_SLOT_LASTPPS = 3'd2;
   localparam logic [RB_SEL_W-1:0] RB_SLOT_GPIO    = 3'd3;
   localparam logic [RB_SEL_W-1:0] RB_SLOT_CTRL    = 3'd4;

endpackage

/* src/radio_axil_pkg.sv */
package radio_axil_pkg;

   localparam int AXIL_ADDR_W = 10;
   localparam int AXIL_DATA_W = 32;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axil_resp_t;

   // Write channel, address and data taken together
   typedef enum logic {
      WR_IDLE,
      WR_RESP
   } wr_state_t;

   typedef enum logic {
      RD_IDLE,
      RD_DATA
   } rd_state_t;

endpackage

/* src/radio_axil_slave.sv */
module radio_axil_slave (
   input  logic                                     radio_clk,
   input  logic                                     i_arst_n,
   input  logic [radio_axil_pkg::AXIL_ADDR_W-1:0]   i_awaddr,
   input  logic                                     i_awvalid,
   output logic                                     o_awready,
   input  logic [radio_axil_pkg::AXIL_DATA_W-1:0]   i_wdata,
   input  logic                                     i_wvalid,
   output logic                                     o_wready,
   output logic [1:0]                               o_bresp,
   output logic                                     o_bvalid,
   input  logic                                     i_bready,
   input  logic [radio_axil_pkg::AXIL_ADDR_W-1:0]   i_araddr,
   input  logic                                     i_arvalid,
   output logic                                     o_arready,
   output logic [radio_axil_pkg::AXIL_DATA_W-1:0]   o_rdata,
   output logic [1:0]                               o_rresp,
   output logic                                     o_rvalid,
   input  logic                                     i_rready,
   output logic                                     o_set_stb,
   output logic [radio_cfg_pkg::SET_ADDR_W-1:0]     o_set_addr,
   output logic [radio_cfg_pkg::SET_DATA_W-1:0]     o_set_data,
   output logic [radio_cfg_pkg::RB_SEL_W-1:0]       o_rb_sel,
   input  logic [radio_cfg_pkg::RB_W-1:0]           i_rb_data
);

   radio_axil_pkg::wr_state_t wr_state;
   radio_axil_pkg::rd_state_t rd_state;
   logic                      wr_accept;
   logic                      rd_accept;

   ////////////////////////////////
   // Write channel
   ////////////////////////////////
   assign o_awready = (wr_state == radio_axil_pkg::WR_IDLE);
   assign o_wready  = (wr_state == radio_axil_pkg::WR_IDLE);
   assign o_bvalid  = (wr_state == radio_axil_pkg::WR_RESP);
   assign o_bresp   = radio_axil_pkg::RESP_OKAY;   // Settings writes never fail
   assign wr_accept = o_awready && i_awvalid && i_wvalid;

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_state  <= radio_axil_pkg::WR_IDLE;
         o_set_stb <= 1'b0;
      end else begin
         o_set_stb <= wr_accept;   // One strobe per accepted write
         case (wr_state)
            radio_axil_pkg::WR_IDLE: if (wr_accept) wr_state <= radio_axil_pkg::WR_RESP;
            radio_axil_pkg::WR_RESP: if (i_bready) wr_state <= radio_axil_pkg::WR_IDLE;
            default: wr_state <= radio_axil_pkg::WR_IDLE;
         endcase
      end
   end

   // Byte address to word address
   always_ff @(posedge radio_clk) begin
      if (wr_accept) begin
         o_set_addr <= i_awaddr[radio_axil_pkg::AXIL_ADDR_W-1:2];
         o_set_data <= i_wdata;
      end
   end

   ////////////////////////////////
   // Read channel
   ////////////////////////////////
   assign o_arready = (rd_state == radio_axil_pkg::RD_IDLE);
   assign o_rvalid  = (rd_state == radio_axil_pkg::RD_DATA);
   assign rd_accept = o_arready && i_arvalid;
   assign o_rb_sel  = i_araddr[5:3];   // Slot goes straight to the mux

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rd_state <= radio_axil_pkg::RD_IDLE;
      end else begin
         case (rd_state)
            radio_axil_pkg::RD_IDLE: if (rd_accept) rd_state <= radio_axil_pkg::RD_DATA;
            radio_axil_pkg::RD_DATA: if (i_rready) rd_state <= radio_axil_pkg::RD_IDLE;
            default: rd_state <= radio_axil_pkg::RD_IDLE;
         endcase
      end
   end

   // Data and response hold while rvalid waits on rready
   always_ff @(posedge radio_clk) begin
      if (rd_accept) begin
         o_rdata <= i_araddr[2] ? i_rb_data[radio_cfg_pkg::RB_W-1:radio_axil_pkg::AXIL_DATA_W]
                                : i_rb_data[radio_axil_pkg::AXIL_DATA_W-1:0];
         if (o_rb_sel >= radio_cfg_pkg::RB_SLOTS)
            o_rresp <= radio_axil_pkg::RESP_SLVERR;
         else
            o_rresp <= radio_axil_pkg::RESP_OKAY;
      end
   end

endmodule

/* src/radio_ctrl_regs.sv */
module radio_ctrl_regs (
   input  logic                                  radio_clk,
   input  logic                                  i_arst_n,
   input  logic                                  i_set_stb,
   input  logic [radio_cfg_pkg::SET_ADDR_W-1:0]  i_set_addr,
   input  logic [radio_cfg_pkg::SET_DATA_W-1:0]  i_set_data,
   output logic [radio_cfg_pkg::SET_DATA_W-1:0]  o_test,
   output logic [radio_cfg_pkg::MISC_W-1:0]      o_misc_outs,
   output logic                                  o_run_rx,
   output logic                                  o_run_tx
);

   logic wr_test;
   logic wr_misc;
   logic wr_run;

   assign wr_test = i_set_stb && (i_set_addr == radio_cfg_pkg::SR_TEST);
   assign wr_misc = i_set_stb && (i_set_addr == radio_cfg_pkg::SR_MISC_OUTS);
   assign wr_run  = i_set_stb && (i_set_addr == radio_cfg_pkg::SR_RUN);

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_test      <= '0;
         o_misc_outs <= '0;
         o_run_rx    <= 1'b0;
         o_run_tx    <= 1'b0;
      end else begin
         if (wr_test) o_test <= i_set_data;   // Scratch word for bus checks
         if (wr_misc) o_misc_outs <= i_set_data[radio_cfg_pkg::MISC_W-1:0];
         // Stand-in for the TX and RX controllers
         if (wr_run) begin
            o_run_rx <= i_set_data[0];
            o_run_tx <= i_set_data[1];
         end
      end
   end

endmodule

/* src/gpio_atr_bank.sv */
module gpio_atr_bank #(
   parameter logic [radio_cfg_pkg::SET_ADDR_W-1:0] BASE = 8'd16
) (
   input  logic                                  radio_clk,
   input  logic                                  i_arst_n,
   input  logic                                  i_set_stb,
   input  logic [radio_cfg_pkg::SET_ADDR_W-1:0]  i_set_addr,
   input  logic [radio_cfg_pkg::SET_DATA_W-1:0]  i_set_data,
   input  logic                                  i_run_rx,
   input  logic                                  i_run_tx,
   input  logic [radio_cfg_pkg::GPIO_W-1:0]      i_gpio_in,
   output logic [radio_cfg_pkg::GPIO_W-1:0]      o_gpio_out,
   output logic [radio_cfg_pkg::GPIO_W-1:0]      o_gpio_oe,
   output logic [radio_cfg_pkg::GPIO_W-1:0]      o_gpio_rb
);

   logic [radio_cfg_pkg::GPIO_W-1:0]     atr_word [4];   // Indexed by ATR state
   logic [radio_cfg_pkg::GPIO_W-1:0]     ddr;
   logic [radio_cfg_pkg::SET_ADDR_W-1:0] offset;
   radio_cfg_pkg::atr_state_t            atr_state;

   assign offset    = i_set_addr - BASE;   // Wraps out of range below BASE
   assign atr_state = radio_cfg_pkg::atr_state_t'({i_run_tx, i_run_rx});

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < 4; i++) begin
            atr_word[i] <= '0;
         end
         ddr <= '0;
      end else if (i_set_stb) begin
         if (offset < radio_cfg_pkg::GPIO_OFF_DDR)
            atr_word[offset[1:0]] <= i_set_data;
         else if (offset == radio_cfg_pkg::GPIO_OFF_DDR)
            ddr <= i_set_data;
      end
   end

   ////////////////////////////////
   // Pin side
   ////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;   // All pins start as inputs
      end else begin
         o_gpio_out <= atr_word[atr_state];
         o_gpio_oe  <= ddr;
      end
   end

   // Input capture for readback
   always_ff @(posedge radio_clk) begin
      o_gpio_rb <= i_gpio_in;
   end

endmodule

/* src/radio_timekeeper.sv */
module radio_timekeeper (
   input  logic                                  radio_clk,
   input  logic                                  i_arst_n,
   input  logic                                  i_set_stb,
   input  logic [radio_cfg_pkg::SET_ADDR_W-1:0]  i_set_addr,
   input  logic [radio_cfg_pkg::SET_DATA_W-1:0]  i_set_data,
   input  logic                                  i_pps,
   output logic [radio_cfg_pkg::TIME_W-1:0]      o_time,
   output logic [radio_cfg_pkg::TIME_W-1:0]      o_time_lastpps
);

   logic [radio_cfg_pkg::SET_DATA_W-1:0] time_hi_pend;
   logic [1:0]                           pps_sync;
   logic                                 pps_dly;
   logic                                 pps_rise;
   logic                                 wr_hi;
   logic                                 wr_lo;

   assign wr_hi    = i_set_stb && (i_set_addr == radio_cfg_pkg::SR_TIME);
   assign wr_lo    = i_set_stb && (i_set_addr == radio_cfg_pkg::SR_TIME + 8'd1);
   assign pps_rise = pps_sync[1] && !pps_dly;

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         time_hi_pend   <= '0;
         o_time         <= '0;
         o_time_lastpps <= '0;
         pps_sync       <= 2'b00;
         pps_dly        <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], i_pps};   // PPS is asynchronous
         pps_dly  <= pps_sync[1];

         if (wr_hi) time_hi_pend <= i_set_data;

         // Low word write loads all 64 bits at once
         if (wr_lo)
            o_time <= {time_hi_pend, i_set_data};
         else
            o_time <= o_time + 1'b1;

         if (pps_rise) o_time_lastpps <= o_time;
      end
   end

endmodule

/* src/radio_readback_mux.sv */
module radio_readback_mux (
   input  logic [radio_cfg_pkg::RB_SEL_W-1:0]                          i_rb_sel,
   input  logic [radio_cfg_pkg::SET_DATA_W-1:0]                        i_test,
   input  logic [radio_cfg_pkg::TIME_W-1:0]                            i_time,
   input  logic [radio_cfg_pkg::TIME_W-1:0]                            i_time_lastpps,
   input  logic [radio_cfg_pkg::NUM_GPIO_BANKS*radio_cfg_pkg::GPIO_W-1:0] i_gpio_rb,
   input  logic [radio_cfg_pkg::MISC_W-1:0]                            i_misc_outs,
   input  logic                                                        i_run_rx,
   input  logic                                                        i_run_tx,
   output logic [radio_cfg_pkg::RB_W-1:0]                              o_rb_data
);

   localparam int GW = radio_cfg_pkg::GPIO_W;

   always_comb begin
      case (i_rb_sel)
         radio_cfg_pkg::RB_SLOT_TEST:    o_rb_data = {i_gpio_rb[GW-1:0], i_test};
         radio_cfg_pkg::RB_SLOT_TIME:    o_rb_data = i_time;
         radio_cfg_pkg::RB_SLOT_LASTPPS: o_rb_data = i_time_lastpps;
         radio_cfg_pkg::RB_SLOT_GPIO:    o_rb_data = {i_gpio_rb[3*GW-1:2*GW],
                                                      i_gpio_rb[2*GW-1:GW]};
         radio_cfg_pkg::RB_SLOT_CTRL: begin
            o_rb_data = '0;
            o_rb_data[radio_cfg_pkg::MISC_W+1:0] = {i_misc_outs, i_run_tx, i_run_rx};
         end
         default:                        o_rb_data = '0;   // Unmapped slots
      endcase
   end

endmodule

/* src/radio_top.sv */
module radio_top (
   input  logic                                                        radio_clk,
   input  logic                                                        i_arst_n,
   input  logic [radio_axil_pkg::AXIL_ADDR_W-1:0]                      i_awaddr,
   input  logic                                                        i_awvalid,
   output logic                                                        o_awready,
   input  logic [radio_axil_pkg::AXIL_DATA_W-1:0]                      i_wdata,
   input  logic                                                        i_wvalid,
   output logic                                                        o_wready,
   output logic [1:0]                                                  o_bresp,
   output logic                                                        o_bvalid,
   input  logic                                                        i_bready,
   input  logic [radio_axil_pkg::AXIL_ADDR_W-1:0]                      i_araddr,
   input  logic                                                        i_arvalid,
   output logic                                                        o_arready,
   output logic [radio_axil_pkg::AXIL_DATA_W-1:0]                      o_rdata,
   output logic [1:0]                                                  o_rresp,
   output logic                                                        o_rvalid,
   input  logic                                                        i_rready,
   input  logic                                                        i_pps,
   input  logic [radio_cfg_pkg::NUM_GPIO_BANKS*radio_cfg_pkg::GPIO_W-1:0] i_gpio_in,
   output logic [radio_cfg_pkg::NUM_GPIO_BANKS*radio_cfg_pkg::GPIO_W-1:0] o_gpio_out,
   output logic [radio_cfg_pkg::NUM_GPIO_BANKS*radio_cfg_pkg::GPIO_W-1:0] o_gpio_oe,
   output logic [radio_cfg_pkg::MISC_W-1:0]                            o_misc_outs
);

   localparam int GW = radio_cfg_pkg::GPIO_W;

   logic                                          set_stb;
   logic [radio_cfg_pkg::SET_ADDR_W-1:0]          set_addr;
   logic [radio_cfg_pkg::SET_DATA_W-1:0]          set_data;
   logic [radio_cfg_pkg::RB_SEL_W-1:0]            rb_sel;
   logic [radio_cfg_pkg::RB_W-1:0]                rb_data;
   logic [radio_cfg_pkg::SET_DATA_W-1:0]          test_rb;
   logic [radio_cfg_pkg::TIME_W-1:0]              radio_time;
   logic [radio_cfg_pkg::TIME_W-1:0]              time_lastpps;
   logic [radio_cfg_pkg::NUM_GPIO_BANKS*GW-1:0]   gpio_rb;
   logic                                          run_rx;
   logic                                          run_tx;

   ////////////////////////////////
   // Control port and settings
   ////////////////////////////////
   radio_axil_slave u_axil_slave (
      .radio_clk  (radio_clk),  .i_arst_n  (i_arst_n),
      .i_awaddr   (i_awaddr),   .i_awvalid (i_awvalid), .o_awready (o_awready),
      .i_wdata    (i_wdata),    .i_wvalid  (i_wvalid),  .o_wready  (o_wready),
      .o_bresp    (o_bresp),    .o_bvalid  (o_bvalid),  .i_bready  (i_bready),
      .i_araddr   (i_araddr),   .i_arvalid (i_arvalid), .o_arready (o_arready),
      .o_rdata    (o_rdata),    .o_rresp   (o_rresp),   .o_rvalid  (o_rvalid),
      .i_rready   (i_rready),
      .o_set_stb  (set_stb),    .o_set_addr (set_addr), .o_set_data (set_data),
      .o_rb_sel   (rb_sel),     .i_rb_data  (rb_data)
   );

   radio_ctrl_regs u_ctrl_regs (
      .radio_clk   (radio_clk),   .i_arst_n   (i_arst_n),
      .i_set_stb   (set_stb),     .i_set_addr (set_addr), .i_set_data (set_data),
      .o_test      (test_rb),     .o_misc_outs (o_misc_outs),
      .o_run_rx    (run_rx),      .o_run_tx    (run_tx)
   );

   radio_timekeeper u_timekeeper (
      .radio_clk   (radio_clk),   .i_arst_n   (i_arst_n),
      .i_set_stb   (set_stb),     .i_set_addr (set_addr), .i_set_data (set_data),
      .i_pps       (i_pps),
      .o_time      (radio_time),  .o_time_lastpps (time_lastpps)
   );

   ////////////////////////////////
   // GPIO ATR banks
   ////////////////////////////////
   for (genvar g = 0; g < radio_cfg_pkg::NUM_GPIO_BANKS; g++) begin : g_gpio_bank
      gpio_atr_bank #(
         .BASE (radio_cfg_pkg::GPIO_BASES[g])
      ) u_bank (
         .radio_clk  (radio_clk),  .i_arst_n   (i_arst_n),
         .i_set_stb  (set_stb),    .i_set_addr (set_addr), .i_set_data (set_data),
         .i_run_rx   (run_rx),     .i_run_tx   (run_tx),
         .i_gpio_in  (i_gpio_in[g*GW +: GW]),
         .o_gpio_out (o_gpio_out[g*GW +: GW]),
         .o_gpio_oe  (o_gpio_oe[g*GW +: GW]),
         .o_gpio_rb  (gpio_rb[g*GW +: GW])
      );
   end

   radio_readback_mux u_rb_mux (
      .i_rb_sel       (rb_sel),
      .i_test         (test_rb),
      .i_time         (radio_time),
      .i_time_lastpps (time_lastpps),
      .i_gpio_rb      (gpio_rb),
      .i_misc_outs    (o_misc_outs),
      .i_run_rx       (run_rx),
      .i_run_tx       (run_tx),
      .o_rb_data      (rb_data)
   );

endmodule

/* bench/radio_tb.sv */
module radio_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int GW = radio_cfg_pkg::GPIO_W;
   localparam int NB = radio_cfg_pkg::NUM_GPIO_BANKS;
   // Test lengths in clock cycles
   localparam int T_RESET = 8;
   localparam int T_REGS  = 40;
   localparam int T_ATR   = 160;
   localparam int T_TIME  = 80;
   localparam int T_BP    = 120;
   localparam int WATCHDOG_CYCLES = 2 * (T_RESET + T_REGS + T_ATR + T_TIME + T_BP);

   logic                  radio_clk;
   logic                  i_arst_n;
   logic [9:0]            i_awaddr;
   logic                  i_awvalid;
   logic                  o_awready;
   logic [31:0]           i_wdata;
   logic                  i_wvalid;
   logic                  o_wready;
   logic [1:0]            o_bresp;
   logic                  o_bvalid;
   logic                  i_bready;
   logic [9:0]            i_araddr;
   logic                  i_arvalid;
   logic                  o_arready;
   logic [31:0]           o_rdata;
   logic [1:0]            o_rresp;
   logic                  o_rvalid;
   logic                  i_rready;
   logic                  i_pps;
   logic [NB*GW-1:0]      i_gpio_in;
   logic [NB*GW-1:0]      o_gpio_out;
   logic [NB*GW-1:0]      o_gpio_oe;
   logic [7:0]            o_misc_outs;

   int seed         = 28;
   int errors       = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   radio_top u_dut (.*);

   initial begin
      radio_clk = 1'b0;
      forever #4 radio_clk = ~radio_clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge radio_clk);
      $display("The watchdog stopped the run because the tests did not finish in time");
      $display("ERRORS FOUND");
      $finish;
   end

   function automatic void report_fail(input string msg);
      $display("FAIL %0t ns: %s", $time, msg);
      errors++;
   endfunction

   function automatic void expect_equal(input string what, input logic [63:0] got,
                                        input logic [63:0] exp);
      assert (got === exp) else report_fail($sformatf("%s is %0h, expected %0h", what, got, exp));
   endfunction

   function automatic void expect_true(input string what, input logic cond);
      assert (cond === 1'b1) else report_fail(what);
   endfunction

   function automatic logic [9:0] setting_byte_addr(input logic [7:0] sr);
      return {sr, 2'b00};
   endfunction

   function automatic logic [9:0] readback_byte_addr(input int slot, input int half);
      return 10'(slot * 8 + half * 4);
   endfunction

   //////////////////////////////
   // Handshake properties
   //////////////////////////////
   a_bvalid_hold: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_bvalid && !i_bready |=> o_bvalid)
      else report_fail("bvalid dropped before bready");
   a_rvalid_hold: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp))
      else report_fail("rvalid, rdata or rresp moved before rready");
   a_write_stall: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_bvalid |-> !o_awready && !o_wready)
      else report_fail("write channel ready while a response waits");
   a_read_stall: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_rvalid |-> !o_arready)
      else report_fail("arready high while read data waits");

   // Called and returns on a falling edge
   task automatic axi_write(input logic [9:0] addr, input logic [31:0] data, input int hold);
      i_awaddr  = addr;
      i_wdata   = data;
      i_awvalid = 1'b1;
      i_wvalid  = 1'b1;
      while (!(o_awready && o_wready)) @(negedge radio_clk);
      @(negedge radio_clk);                 // Accepted on the rising edge just passed
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
      repeat (hold) @(negedge radio_clk);   // bready held low
      expect_true("bvalid low after a write", o_bvalid);
      expect_equal("bresp", o_bresp, radio_axil_pkg::RESP_OKAY);
      i_bready = 1'b1;
      @(negedge radio_clk);
      i_bready = 1'b0;
   endtask

   task automatic axi_read(input logic [9:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
      i_araddr  = addr;
      i_arvalid = 1'b1;
      while (!o_arready) @(negedge radio_clk);
      @(negedge radio_clk);
      i_arvalid = 1'b0;
      repeat (hold) @(negedge radio_clk);   // rready held low
      expect_true("rvalid low after a read", o_rvalid);
      data     = o_rdata;
      resp     = o_rresp;
      i_rready = 1'b1;
      @(negedge radio_clk);
      i_rready = 1'b0;
   endtask

   // Low half first, then high half
   task automatic read_slot64(input int slot, output logic [63:0] value);
      logic [1:0] resp;
      axi_read(readback_byte_addr(slot, 0), 0, value[31:0], resp);
      expect_equal($sformatf("slot %0d low resp", slot), resp, radio_axil_pkg::RESP_OKAY);
      axi_read(readback_byte_addr(slot, 1), 0, value[63:32], resp);
      expect_equal($sformatf("slot %0d high resp", slot), resp, radio_axil_pkg::RESP_OKAY);
   endtask

   task automatic end_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: failed, %0d bad checks", name, errors - errors_before);
      end
   endtask

   initial begin
      logic [31:0] test_val;
      logic [31:0] rnd;
      logic [31:0] rd_data;
      logic [1:0]  rd_resp;
      logic [31:0] atr_words [5];
      logic [95:0] gpio_val;
      logic [63:0] load_time;
      logic [63:0] now_time;
      logic [63:0] pps_time;
      int          mark;

      i_arst_n  = 1'b0;
      i_awaddr  = '0;
      i_awvalid = 1'b0;
      i_wdata   = '0;
      i_wvalid  = 1'b0;
      i_bready  = 1'b0;
      i_araddr  = '0;
      i_arvalid = 1'b0;
      i_rready  = 1'b0;
      i_pps     = 1'b0;
      i_gpio_in = '0;
      repeat (3) @(negedge radio_clk);
      i_arst_n = 1'b1;
      @(negedge radio_clk);

      mark = errors;
      expect_equal("bvalid after reset", o_bvalid, 0);
      expect_equal("rvalid after reset", o_rvalid, 0);
      expect_true("gpio out not zero after reset", o_gpio_out == '0);
      expect_true("gpio oe not zero after reset", o_gpio_oe == '0);
      expect_equal("misc outputs after reset", o_misc_outs, 0);
      expect_true("a ready signal is low after reset", o_awready && o_wready && o_arready);
      end_test("reset state", mark);

      mark = errors;
      test_val = $random(seed);
      rnd      = $random(seed);
      axi_write(setting_byte_addr(radio_cfg_pkg::SR_TEST), test_val, 0);
      axi_write(setting_byte_addr(radio_cfg_pkg::SR_MISC_OUTS), {24'd0, rnd[7:0]}, 0);
      expect_equal("misc outputs", o_misc_outs, rnd[7:0]);
      axi_read(readback_byte_addr(0, 0), 0, rd_data, rd_resp);
      expect_equal("test register readback", rd_data, test_val);
      axi_read(readback_byte_addr(4, 0), 0, rd_data, rd_resp);
      expect_equal("misc and run flags readback", rd_data, {22'd0, rnd[7:0], 2'b00});
      axi_read(readback_byte_addr(4, 1), 0, rd_data, rd_resp);
      expect_equal("slot 4 high half", rd_data, 0);
      end_test("registers", mark);

      mark = errors;
      for (int b = 0; b < NB; b++) begin
         for (int k = 0; k < 5; k++) begin
            atr_words[k] = $random(seed);
            axi_write(setting_byte_addr(radio_cfg_pkg::GPIO_BASES[b] + 8'(k)), atr_words[k], 0);
         end
         for (int r = 0; r < 4; r++) begin
            axi_write(setting_byte_addr(radio_cfg_pkg::SR_RUN), 32'(r), 0);
            @(negedge radio_clk);   // Bank output lags the run flags by one cycle
            expect_equal($sformatf("bank %0d out, run %0d", b, r),
                         o_gpio_out[b*GW +: GW], atr_words[r]);
            expect_equal($sformatf("bank %0d oe", b), o_gpio_oe[b*GW +: GW], atr_words[4]);
            axi_read(readback_byte_addr(4, 0), 0, rd_data, rd_resp);
            expect_equal($sformatf("run flags readback, run %0d", r), rd_data,
                         {22'd0, rnd[7:0], 2'(r)});
         end
      end
      gpio_val  = {$random(seed), $random(seed), $random(seed)};
      i_gpio_in = gpio_val;
      @(negedge radio_clk);
      axi_read(readback_byte_addr(0, 1), 0, rd_data, rd_resp);
      expect_equal("bank 0 input", rd_data, gpio_val[31:0]);
      axi_read(readback_byte_addr(3, 0), 0, rd_data, rd_resp);
      expect_equal("bank 1 input", rd_data, gpio_val[63:32]);
      axi_read(readback_byte_addr(3, 1), 0, rd_data, rd_resp);
      expect_equal("bank 2 input", rd_data, gpio_val[95:64]);
      end_test("ATR banks", mark);

      mark = errors;
      load_time[63:32] = $random(seed);
      rnd              = $random(seed);
      load_time[31:0]  = {4'h0, rnd[27:0]};   // No carry into the high word during the test
      axi_write(setting_byte_addr(radio_cfg_pkg::SR_TIME), load_time[63:32], 0);
      axi_write(setting_byte_addr(radio_cfg_pkg::SR_TIME + 8'd1), load_time[31:0], 0);
      read_slot64(1, now_time);
      expect_true("radio time below the loaded value", now_time >= load_time);
      expect_true("radio time too far past the load", now_time < load_time + 64'd100);
      i_pps = 1'b1;
      repeat (4) @(negedge radio_clk);
      i_pps = 1'b0;
      repeat (4) @(negedge radio_clk);
      read_slot64(2, pps_time);
      read_slot64(1, now_time);
      expect_true("PPS time below the loaded value", pps_time >= load_time);
      expect_true("PPS time past the current time", pps_time <= now_time);
      end_test("timekeeper", mark);

      mark = errors;
      test_val = $random(seed);
      axi_write(setting_byte_addr(radio_cfg_pkg::SR_TEST), test_val, 2 + ($random(seed) & 7));
      axi_read(readback_byte_addr(0, 0), 2 + ($random(seed) & 7), rd_data, rd_resp);
      expect_equal("test register after stall", rd_data, test_val);
      expect_equal("resp after stall", rd_resp, radio_axil_pkg::RESP_OKAY);
      axi_read(readback_byte_addr(6, 0), 2 + ($random(seed) & 7), rd_data, rd_resp);
      expect_equal("slot 6 data", rd_data, 0);
      expect_equal("slot 6 resp", rd_resp, radio_axil_pkg::RESP_SLVERR);
      end_test("back-pressure and errors", mark);

      $display("Tests run: %0d, tests failed: %0d, bad checks: %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* radio.f */
src/radio_cfg_pkg.sv
src/radio_axil_pkg.sv
src/radio_axil_slave.sv
src/radio_ctrl_regs.sv
src/gpio_atr_bank.sv
src/radio_timekeeper.sv
src/radio_readback_mux.sv
src/radio_top.sv
bench/radio_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the radio control-plane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module radio_tb -f radio.f -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vradio_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
